//--- Bender.yml
package:
  name: io_subsystem

sources:
  - common/soc_config_pkg.sv
  - common/io_map_pkg.sv
  - source/io_arbiter.sv
  - source/performance_counters.sv
  - source/interrupt_controller.sv
  - source/io_subsystem.sv
  - target: test
    files:
      - test/io_subsystem_sva.sv
      - test/io_subsystem_tb.sv

//--- common/io_map_pkg.sv
package io_map_pkg;

	// Interrupt controller register block
	localparam soc_config_pkg::scalar_t INT_CONTROLLER_BASE = 'h60;

	// Offsets from INT_CONTROLLER_BASE, one word apart
	localparam soc_config_pkg::scalar_t THREAD_EN_SET_OFFSET = 'h0;
	localparam soc_config_pkg::scalar_t THREAD_EN_CLEAR_OFFSET = 'h4;
	localparam soc_config_pkg::scalar_t INT_TRIGGER_OFFSET = 'h8;

	// Counter i sits at PERF_COUNTER_BASE + 4 * i
	localparam soc_config_pkg::scalar_t PERF_COUNTER_BASE = 'h130;
	localparam soc_config_pkg::scalar_t PERF_COUNTER_LAST = 'h13c;

	// Where the arbiter's read data comes from
	typedef enum logic {
		IO_PERF_COUNTERS,
		IO_ARBITER
	} io_read_source_t;

	// Arbiter sequencing
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_ISSUE,
		ARB_RESPOND
	} io_arb_state_t;

endpackage

//--- common/soc_config_pkg.sv
package soc_config_pkg;

	// Core and thread counts
	localparam NUM_CORES = 2;
	localparam THREADS_PER_CORE = 2;
	localparam TOTAL_THREADS = NUM_CORES * THREADS_PER_CORE;

	// Index widths derived from the counts above
	localparam CORE_ID_WIDTH = $clog2(NUM_CORES);
	localparam THREAD_IDX_WIDTH = $clog2(THREADS_PER_CORE);

	// Event lines into the performance counter block
	localparam NUM_PERF_EVENTS = 4;
	localparam PERF_EVENT_IDX_WIDTH = $clog2(NUM_PERF_EVENTS);

	// One data or address word
	typedef logic [31:0] scalar_t;

	// Which core issued a request
	typedef logic [CORE_ID_WIDTH - 1:0] core_id_t;

	// Thread within its core
	typedef logic [THREAD_IDX_WIDTH - 1:0] thread_idx_t;

	// Selects one counter
	typedef logic [PERF_EVENT_IDX_WIDTH - 1:0] perf_event_idx_t;

endpackage

//--- io_subsystem.f
common/soc_config_pkg.sv
common/io_map_pkg.sv
source/io_arbiter.sv
source/performance_counters.sv
source/interrupt_controller.sv
source/io_subsystem.sv
test/io_subsystem_sva.sv
test/io_subsystem_tb.sv

//--- source/interrupt_controller.sv
module interrupt_controller(
	input clk,
	input reset,

	// Writes observed on the I/O bus
	input io_write_en,
	input soc_config_pkg::scalar_t io_address,
	input soc_config_pkg::scalar_t io_write_data,

	// Interrupt sources and acknowledges
	input interrupt_req,
	input logic wb_interrupt_ack[soc_config_pkg::NUM_CORES],

	output logic [soc_config_pkg::TOTAL_THREADS - 1:0] ic_thread_en,
	output logic ic_interrupt_pending[soc_config_pkg::NUM_CORES],
	output logic processor_halt);

	import soc_config_pkg::*;
	import io_map_pkg::*;

	logic set_write;
	logic clear_write;
	logic trigger_write;
	logic interrupt_req_prev;
	logic interrupt_req_rise;

	// Register decode
	assign set_write = io_write_en
		&& io_address == INT_CONTROLLER_BASE + THREAD_EN_SET_OFFSET;
	assign clear_write = io_write_en
		&& io_address == INT_CONTROLLER_BASE + THREAD_EN_CLEAR_OFFSET;
	assign trigger_write = io_write_en
		&& io_address == INT_CONTROLLER_BASE + INT_TRIGGER_OFFSET;

	// External line is level, only a rising edge counts
	assign interrupt_req_rise = interrupt_req && !interrupt_req_prev;

	// Thread enables, thread 0 runs out of reset
	always_ff @(posedge clk)
	begin
		if (reset)
			ic_thread_en <= TOTAL_THREADS'(1);
		else if (set_write)
			ic_thread_en <= ic_thread_en | io_write_data[TOTAL_THREADS - 1:0];
		else if (clear_write)
			ic_thread_en <= ic_thread_en & ~io_write_data[TOTAL_THREADS - 1:0];
	end

	// Pending bits, one per core
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			interrupt_req_prev <= 1'b0;
			for (int i = 0; i < NUM_CORES; i++)
				ic_interrupt_pending[i] <= 1'b0;
		end
		else
		begin
			interrupt_req_prev <= interrupt_req;
			for (int i = 0; i < NUM_CORES; i++)
			begin
				// A new request beats an ack in the same cycle
				if ((trigger_write && io_write_data[i]) || (i == 0 && interrupt_req_rise))
					ic_interrupt_pending[i] <= 1'b1;
				else if (wb_interrupt_ack[i])
					ic_interrupt_pending[i] <= 1'b0;
			end
		end
	end

	// Nothing left to run
	assign processor_halt = ic_thread_en == '0;

endmodule

//--- source/io_arbiter.sv
module io_arbiter(
	input clk,
	input reset,

	// Requests from the cores
	input logic ior_request_valid[soc_config_pkg::NUM_CORES],
	input logic ior_store[soc_config_pkg::NUM_CORES],
	input soc_config_pkg::scalar_t ior_address[soc_config_pkg::NUM_CORES],
	input soc_config_pkg::scalar_t ior_store_value[soc_config_pkg::NUM_CORES],
	input soc_config_pkg::thread_idx_t ior_thread_idx[soc_config_pkg::NUM_CORES],
	output logic ia_ready[soc_config_pkg::NUM_CORES],

	// External I/O bus
	output logic io_read_en,
	output logic io_write_en,
	output soc_config_pkg::scalar_t io_address,
	output soc_config_pkg::scalar_t io_write_data,
	input soc_config_pkg::scalar_t io_read_data,

	// Response back to the cores
	output logic ia_response_valid,
	output soc_config_pkg::core_id_t ia_response_core,
	output soc_config_pkg::thread_idx_t ia_response_thread,
	output soc_config_pkg::scalar_t ia_response_read_value);

	import soc_config_pkg::*;
	import io_map_pkg::*;

	io_arb_state_t state;
	core_id_t rr_pointer;
	core_id_t grant_idx;
	core_id_t next_pointer;
	logic grant_found;
	logic accept;
	logic capture;
	core_id_t req_core;
	thread_idx_t req_thread;
	logic req_store;

	// First valid core at or after the pointer
	always_comb
	begin
		grant_found = 1'b0;
		grant_idx = '0;
		for (int i = 0; i < NUM_CORES; i++)
		begin
			int candidate;
			candidate = (int'(rr_pointer) + i) % NUM_CORES;
			if (!grant_found && ior_request_valid[candidate])
			begin
				grant_found = 1'b1;
				grant_idx = core_id_t'(candidate);
			end
		end
	end

	// Ready only to the chosen core, only when nothing is in flight
	always_comb
	begin
		for (int i = 0; i < NUM_CORES; i++)
			ia_ready[i] = state == ARB_IDLE && grant_found && grant_idx == core_id_t'(i);
	end

	assign accept = state == ARB_IDLE && grant_found;

	// Pointer moves past the core just served
	assign next_pointer = grant_idx == core_id_t'(NUM_CORES - 1) ? '0 : grant_idx + 1'b1;

	// Second ISSUE cycle, strobe already dropped, device data now valid
	assign capture = state == ARB_ISSUE && !io_read_en && !io_write_en;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ARB_IDLE;
			rr_pointer <= '0;
			io_read_en <= 1'b0;
			io_write_en <= 1'b0;
		end
		else
		begin
			case (state)
				ARB_IDLE:
				begin
					if (accept)
					begin
						io_read_en <= !ior_store[grant_idx];
						io_write_en <= ior_store[grant_idx];
						rr_pointer <= next_pointer;
						state <= ARB_ISSUE;
					end
				end

				ARB_ISSUE:
				begin
					// Strobes last one cycle, then wait out the read latency
					if (io_read_en || io_write_en)
					begin
						io_read_en <= 1'b0;
						io_write_en <= 1'b0;
					end
					else
						state <= ARB_RESPOND;
				end

				ARB_RESPOND:
					state <= ARB_IDLE;

				default:
					state <= ARB_IDLE;
			endcase
		end
	end

	// Latched request, held on the bus until the next acceptance
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			req_core <= grant_idx;
			req_thread <= ior_thread_idx[grant_idx];
			req_store <= ior_store[grant_idx];
			io_address <= ior_address[grant_idx];
			io_write_data <= ior_store_value[grant_idx];
		end

		// Stores answer with zero
		if (capture)
			ia_response_read_value <= req_store ? '0 : io_read_data;
	end

	assign ia_response_valid = state == ARB_RESPOND;
	assign ia_response_core = req_core;
	assign ia_response_thread = req_thread;

endmodule

//--- source/io_subsystem.sv
module io_subsystem(
	input clk,
	input reset,

	// Core request side
	input logic ior_request_valid[soc_config_pkg::NUM_CORES],
	input logic ior_store[soc_config_pkg::NUM_CORES],
	input soc_config_pkg::scalar_t ior_address[soc_config_pkg::NUM_CORES],
	input soc_config_pkg::scalar_t ior_store_value[soc_config_pkg::NUM_CORES],
	input soc_config_pkg::thread_idx_t ior_thread_idx[soc_config_pkg::NUM_CORES],
	output logic ia_ready[soc_config_pkg::NUM_CORES],
	output logic ia_response_valid,
	output soc_config_pkg::core_id_t ia_response_core,
	output soc_config_pkg::thread_idx_t ia_response_thread,
	output soc_config_pkg::scalar_t ia_response_read_value,

	// External I/O bus
	output logic io_read_en,
	output logic io_write_en,
	output soc_config_pkg::scalar_t io_address,
	output soc_config_pkg::scalar_t io_write_data,
	input soc_config_pkg::scalar_t io_read_data,

	// Event pulses, interrupts, thread control
	input [soc_config_pkg::NUM_PERF_EVENTS - 1:0] perf_events,
	input interrupt_req,
	input logic wb_interrupt_ack[soc_config_pkg::NUM_CORES],
	output logic [soc_config_pkg::TOTAL_THREADS - 1:0] ic_thread_en,
	output logic ic_interrupt_pending[soc_config_pkg::NUM_CORES],
	output logic processor_halt);

	import soc_config_pkg::*;
	import io_map_pkg::*;

	scalar_t perf_io_read_data;
	scalar_t selected_io_read_data;
	io_read_source_t io_read_source;

	// Follows the bus address one cycle behind, lines up with counter read data
	always_ff @(posedge clk)
	begin
		if (io_address >= PERF_COUNTER_BASE && io_address <= PERF_COUNTER_LAST)
			io_read_source <= IO_PERF_COUNTERS;
		else
			io_read_source <= IO_ARBITER;
	end

	// External data is dropped for counter addresses
	always_comb
	begin
		case (io_read_source)
			IO_PERF_COUNTERS: selected_io_read_data = perf_io_read_data;
			default: selected_io_read_data = io_read_data;
		endcase
	end

	io_arbiter io_arbiter(
		.io_read_data(selected_io_read_data),
		.*);

	performance_counters performance_counters(.*);

	// Sees the same writes as the external device
	interrupt_controller interrupt_controller(.*);

endmodule

//--- source/performance_counters.sv
module performance_counters(
	input clk,
	input reset,
	input [soc_config_pkg::NUM_PERF_EVENTS - 1:0] perf_events,
	input soc_config_pkg::scalar_t io_address,
	output soc_config_pkg::scalar_t perf_io_read_data);

	import soc_config_pkg::*;
	import io_map_pkg::*;

	scalar_t event_count[NUM_PERF_EVENTS];
	scalar_t counter_offset;
	perf_event_idx_t counter_idx;

	// Word index relative to the counter block
	assign counter_offset = io_address - PERF_COUNTER_BASE;
	assign counter_idx = counter_offset[2+:PERF_EVENT_IDX_WIDTH];

	// One count per cycle the event line is high
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_PERF_EVENTS; i++)
				event_count[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < NUM_PERF_EVENTS; i++)
			begin
				if (perf_events[i])
					event_count[i] <= event_count[i] + 1'b1;
			end
		end
	end

	// Registered read, one cycle after the address
	// Out-of-range addresses are filtered by the top level
	always_ff @(posedge clk)
		perf_io_read_data <= event_count[counter_idx];

endmodule

//--- test/io_subsystem_sva.sv
module io_subsystem_sva(
	input clk,
	input reset,
	input logic ior_request_valid[soc_config_pkg::NUM_CORES],
	input logic ia_ready[soc_config_pkg::NUM_CORES],
	input logic io_read_en,
	input logic io_write_en,
	input logic ia_response_valid);

	import soc_config_pkg::*;

	logic [NUM_CORES - 1:0] ready_bits;
	logic [NUM_CORES - 1:0] accept_bits;
	int assertion_failures = 0;

	// Packed views of the per-core arrays
	always_comb
	begin
		for (int i = 0; i < NUM_CORES; i++)
		begin
			ready_bits[i] = ia_ready[i];
			accept_bits[i] = ia_ready[i] && ior_request_valid[i];
		end
	end

	// One grant at a time
	ready_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(ready_bits))
		else
		begin
			$error("more than one ia_ready bit high");
			assertion_failures++;
		end

	strobe_exclusive: assert property (@(posedge clk) disable iff (reset)
		!(io_read_en && io_write_en))
		else
		begin
			$error("io_read_en and io_write_en high together");
			assertion_failures++;
		end

	// Strobes are single-cycle pulses
	strobe_single: assert property (@(posedge clk) disable iff (reset)
		(io_read_en || io_write_en) |=> !(io_read_en || io_write_en))
		else
		begin
			$error("I/O strobe longer than one cycle");
			assertion_failures++;
		end

	// Response lands on the third cycle after acceptance, not before
	response_timing: assert property (@(posedge clk) disable iff (reset)
		accept_bits != '0 |=> !ia_response_valid ##1 !ia_response_valid ##1 ia_response_valid)
		else
		begin
			$error("response not exactly three cycles after acceptance");
			assertion_failures++;
		end

endmodule

bind io_subsystem io_subsystem_sva io_subsystem_sva_inst(
	.clk(clk),
	.reset(reset),
	.ior_request_valid(ior_request_valid),
	.ia_ready(ia_ready),
	.io_read_en(io_read_en),
	.io_write_en(io_write_en),
	.ia_response_valid(ia_response_valid));

//--- test/io_subsystem_tb.sv
module io_subsystem_tb;

	import soc_config_pkg::*;
	import io_map_pkg::*;

	// About 300 cycles of tests, generous margin
	localparam CYCLE_LIMIT = 2000;
	localparam scalar_t DEVICE_PATTERN = 32'hA5A5_0000;

	logic clk;
	logic reset;
	logic ior_request_valid[NUM_CORES];
	logic ior_store[NUM_CORES];
	scalar_t ior_address[NUM_CORES];
	scalar_t ior_store_value[NUM_CORES];
	thread_idx_t ior_thread_idx[NUM_CORES];
	logic ia_ready[NUM_CORES];
	logic ia_response_valid;
	core_id_t ia_response_core;
	thread_idx_t ia_response_thread;
	scalar_t ia_response_read_value;
	logic io_read_en;
	logic io_write_en;
	scalar_t io_address;
	scalar_t io_write_data;
	scalar_t io_read_data;
	logic [NUM_PERF_EVENTS - 1:0] perf_events;
	logic interrupt_req;
	logic wb_interrupt_ack[NUM_CORES];
	logic [TOTAL_THREADS - 1:0] ic_thread_en;
	logic ic_interrupt_pending[NUM_CORES];
	logic processor_halt;

	int seed;
	int error_count;
	int tests_ok;
	int tests_bad;
	int sva_failures;
	int cycle_count = 0;
	// Expected round-robin pointer
	core_id_t rr_pointer_model;

	io_subsystem io_subsystem_inst(.*);

	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	// External device, data follows the held address
	always @(negedge clk)
		io_read_data <= io_address ^ DEVICE_PATTERN;

	// Hang guard
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
		begin
			$display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	task automatic report_mismatch(input string name, input scalar_t got, input scalar_t expected);
		$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, expected);
		error_count++;
	endtask

	task automatic finish_test(input string name, input int errors_before);
		if (error_count == errors_before)
		begin
			tests_ok++;
			$display("%s: ok", name);
		end
		else
		begin
			tests_bad++;
			$display("%s: %0d errors", name, error_count - errors_before);
		end
	endtask

	// Word aligned, above every mapped register
	task automatic random_external_address(output scalar_t addr);
		addr = $random(seed);
		addr = (addr | 32'h1000) & 32'hFFFF_FFFC;
	endtask

	task automatic set_request(input int core, input logic store, input scalar_t addr,
		input scalar_t data, input thread_idx_t thread);
		ior_request_valid[core] = 1'b1;
		ior_store[core] = store;
		ior_address[core] = addr;
		ior_store_value[core] = data;
		ior_thread_idx[core] = thread;
	endtask

	// First valid core at or after the expected pointer
	function automatic int expected_winner();
		int c;
		for (int offset = 0; offset < NUM_CORES; offset++)
		begin
			c = (int'(rr_pointer_model) + offset) % NUM_CORES;
			if (ior_request_valid[c])
				return c;
		end
		return 0;
	endfunction

	// Called just after a falling edge with the request in place
	task automatic complete_request(input int core, input scalar_t expect_value);
		int other;
		int waited;
		logic store;
		scalar_t addr;
		scalar_t data;
		thread_idx_t thread;
		other = (core + 1) % NUM_CORES;
		waited = 0;
		store = ior_store[core];
		addr = ior_address[core];
		data = ior_store_value[core];
		thread = ior_thread_idx[core];

		// Ready sampled mid-cycle
		#10;
		while (!ia_ready[core] && !ia_ready[other] && waited < 20)
		begin
			@(negedge clk);
			#10;
			waited++;
		end
		if (!ia_ready[core] || ia_ready[other])
		begin
			$display("Error: core %0d not granted alone, ready core %0d %0b, core %0d %0b",
				core, core, ia_ready[core], other, ia_ready[other]);
			error_count++;
			@(negedge clk);
			ior_request_valid[core] = 1'b0;
			return;
		end
		rr_pointer_model = core_id_t'(other);

		// Strobe cycle
		@(negedge clk);
		if (io_write_en !== store)
			report_mismatch("io_write_en", io_write_en, store);
		if (io_read_en !== !store)
			report_mismatch("io_read_en", io_read_en, !store);
		if (io_address !== addr)
			report_mismatch("io_address", io_address, addr);
		if (store && io_write_data !== data)
			report_mismatch("io_write_data", io_write_data, data);
		if (ia_response_valid !== 1'b0)
			report_mismatch("ia_response_valid", ia_response_valid, 0);
		if (ia_ready[other] !== 1'b0)
			report_mismatch("ia_ready of waiting core", ia_ready[other], 0);
		ior_request_valid[core] = 1'b0;

		// Device data cycle
		@(negedge clk);
		if (io_write_en !== 1'b0)
			report_mismatch("io_write_en", io_write_en, 0);
		if (io_read_en !== 1'b0)
			report_mismatch("io_read_en", io_read_en, 0);
		if (ia_response_valid !== 1'b0)
			report_mismatch("ia_response_valid", ia_response_valid, 0);
		if (ia_ready[other] !== 1'b0)
			report_mismatch("ia_ready of waiting core", ia_ready[other], 0);

		// Response, third cycle after acceptance
		@(negedge clk);
		if (ia_response_valid !== 1'b1)
			report_mismatch("ia_response_valid", ia_response_valid, 1);
		if (ia_response_core !== core_id_t'(core))
			report_mismatch("ia_response_core", ia_response_core, core);
		if (ia_response_thread !== thread)
			report_mismatch("ia_response_thread", ia_response_thread, thread);
		if (ia_response_read_value !== expect_value)
			report_mismatch("ia_response_read_value", ia_response_read_value, expect_value);
		if (ia_ready[other] !== 1'b0)
			report_mismatch("ia_ready of waiting core", ia_ready[other], 0);
	endtask

	task automatic store_word(input int core, input scalar_t addr, input scalar_t data,
		input thread_idx_t thread);
		@(negedge clk);
		set_request(core, 1'b1, addr, data, thread);
		complete_request(core, '0);
	endtask

	task automatic load_word(input int core, input scalar_t addr, input thread_idx_t thread,
		input scalar_t expect_value);
		@(negedge clk);
		set_request(core, 1'b0, addr, '0, thread);
		complete_request(core, expect_value);
	endtask

	task automatic check_pending(input logic [NUM_CORES - 1:0] expected);
		for (int i = 0; i < NUM_CORES; i++)
		begin
			if (ic_interrupt_pending[i] !== expected[i])
				report_mismatch($sformatf("ic_interrupt_pending[%0d]", i),
					ic_interrupt_pending[i], expected[i]);
		end
	endtask

	task automatic pulse_ack(input int core);
		@(negedge clk);
		wb_interrupt_ack[core] = 1'b1;
		@(negedge clk);
		wb_interrupt_ack[core] = 1'b0;
	endtask

	task automatic test_external_store();
		int errors_before;
		scalar_t addr;
		scalar_t data;
		errors_before = error_count;
		random_external_address(addr);
		data = $random(seed);
		store_word(0, addr, data, 1'b1);
		finish_test("external store", errors_before);
	endtask

	task automatic test_external_load();
		int errors_before;
		scalar_t addr;
		thread_idx_t thread;
		errors_before = error_count;
		// Ends on core 1, pointer back at core 0
		for (int i = 0; i < 6; i++)
		begin
			random_external_address(addr);
			thread = thread_idx_t'($random(seed));
			load_word(i % NUM_CORES, addr, thread, addr ^ DEVICE_PATTERN);
		end
		finish_test("external load", errors_before);
	endtask

	task automatic test_round_robin();
		int errors_before;
		int winner;
		scalar_t addr;
		errors_before = error_count;
		@(negedge clk);
		for (int c = 0; c < NUM_CORES; c++)
		begin
			random_external_address(addr);
			set_request(c, 1'b0, addr, '0, thread_idx_t'(c));
		end
		for (int i = 0; i < 6; i++)
		begin
			winner = expected_winner();
			complete_request(winner, ior_address[winner] ^ DEVICE_PATTERN);
			// Served core asks again, the other one is still waiting
			if (i < 4)
			begin
				@(negedge clk);
				random_external_address(addr);
				set_request(winner, 1'b0, addr, '0, thread_idx_t'(winner));
			end
		end
		finish_test("round robin", errors_before);
	endtask

	task automatic test_counter_read();
		int errors_before;
		int counts[NUM_PERF_EVENTS];
		errors_before = error_count;
		counts = '{3, 6, 1, 4};
		for (int cyc = 0; cyc < 8; cyc++)
		begin
			@(negedge clk);
			for (int e = 0; e < NUM_PERF_EVENTS; e++)
				perf_events[e] = cyc < counts[e];
		end
		@(negedge clk);
		perf_events = '0;
		for (int e = 0; e < NUM_PERF_EVENTS; e++)
			load_word(e % NUM_CORES, PERF_COUNTER_BASE + scalar_t'(4 * e), '0,
				scalar_t'(counts[e]));
		finish_test("counter read", errors_before);
	endtask

	task automatic test_thread_enable();
		int errors_before;
		logic [TOTAL_THREADS - 1:0] expect_en;
		logic op_set[4];
		logic [TOTAL_THREADS - 1:0] op_mask[4];
		scalar_t data;
		errors_before = error_count;
		op_set = '{1'b1, 1'b0, 1'b0, 1'b1};
		op_mask = '{4'b1010, 4'b0011, 4'b1000, 4'b0101};
		expect_en = 1;
		if (ic_thread_en !== expect_en)
			report_mismatch("ic_thread_en", ic_thread_en, expect_en);
		for (int i = 0; i < 4; i++)
		begin
			// Random upper bits outside the mask
			data = $random(seed);
			data[TOTAL_THREADS - 1:0] = op_mask[i];
			if (op_set[i])
			begin
				store_word(i % NUM_CORES, INT_CONTROLLER_BASE + THREAD_EN_SET_OFFSET, data, '0);
				expect_en = expect_en | op_mask[i];
			end
			else
			begin
				store_word(i % NUM_CORES, INT_CONTROLLER_BASE + THREAD_EN_CLEAR_OFFSET, data, '0);
				expect_en = expect_en & ~op_mask[i];
			end
			if (ic_thread_en !== expect_en)
				report_mismatch("ic_thread_en", ic_thread_en, expect_en);
			if (processor_halt !== (expect_en == '0))
				report_mismatch("processor_halt", processor_halt, expect_en == '0);
		end
		finish_test("thread enable", errors_before);
	endtask

	task automatic test_interrupts();
		int errors_before;
		errors_before = error_count;
		check_pending(2'b00);
		store_word(0, INT_CONTROLLER_BASE + INT_TRIGGER_OFFSET, 32'h2, '0);
		check_pending(2'b10);
		store_word(1, INT_CONTROLLER_BASE + INT_TRIGGER_OFFSET, 32'h1, '0);
		check_pending(2'b11);
		pulse_ack(1);
		check_pending(2'b01);
		pulse_ack(0);
		check_pending(2'b00);

		// External line, edge sets core 0 only
		@(negedge clk);
		interrupt_req = 1'b1;
		@(negedge clk);
		check_pending(2'b01);
		pulse_ack(0);
		check_pending(2'b00);
		// Held level must not retrigger
		repeat (3) @(negedge clk);
		check_pending(2'b00);
		interrupt_req = 1'b0;
		finish_test("interrupts", errors_before);
	endtask

	initial
	begin
		seed = 32'h642a8335;
		error_count = 0;
		tests_ok = 0;
		tests_bad = 0;
		rr_pointer_model = '0;
		reset = 1'b1;
		interrupt_req = 1'b0;
		perf_events = '0;
		io_read_data = '0;
		for (int c = 0; c < NUM_CORES; c++)
		begin
			ior_request_valid[c] = 1'b0;
			ior_store[c] = 1'b0;
			ior_address[c] = '0;
			ior_store_value[c] = '0;
			ior_thread_idx[c] = '0;
			wb_interrupt_ack[c] = 1'b0;
		end
		repeat (5) @(negedge clk);
		reset = 1'b0;

		test_external_store();
		test_external_load();
		test_round_robin();
		test_counter_read();
		test_thread_enable();
		test_interrupts();

		// Bound protocol checker failures
		sva_failures = io_subsystem_inst.io_subsystem_sva_inst.assertion_failures;
		$display("Summary: %0d tests ok, %0d tests with errors, %0d assertion failures",
			tests_ok, tests_bad, sva_failures);
		if (tests_bad == 0 && error_count == 0 && sva_failures == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule
